/* filelist.f */
rtl/epu_pkg.sv
rtl/epu_buffer.sv
rtl/epu_ctrl_regs.sv
rtl/epu_conv_engine.sv
rtl/epu_axi_slave.sv
rtl/epu_top.sv
test/epu_chk.sv
test/epu_tb.sv

/* rtl/epu_axi_slave.sv */
`timescale 1ns/10ps
`default_nettype none

module epu_axi_slave import epu_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  // Write address
  input  logic      s_awvalid_i,
  output logic      s_awready_o,
  input  axi_addr_t s_awaddr_i,
  input  axi_id_t   s_awid_i,
  input  axi_len_t  s_awlen_i,
  // Write data
  input  logic      s_wvalid_i,
  output logic      s_wready_o,
  input  axi_data_t s_wdata_i,
  input  logic      s_wlast_i,
  // Write response
  output logic      s_bvalid_o,
  input  logic      s_bready_i,
  output axi_id_t   s_bid_o,
  output axi_resp_t s_bresp_o,
  // Read address
  input  logic      s_arvalid_i,
  output logic      s_arready_o,
  input  axi_addr_t s_araddr_i,
  input  axi_id_t   s_arid_i,
  input  axi_len_t  s_arlen_i,
  // Read data
  output logic      s_rvalid_o,
  input  logic      s_rready_i,
  output axi_data_t s_rdata_o,
  output axi_id_t   s_rid_o,
  output axi_resp_t s_rresp_o,
  output logic      s_rlast_o,
  // Buffer bus
  output buf_addr_t bus_addr_o,
  output axi_data_t bus_wdata_o,
  output logic      in_we_o,
  output logic      wgt_we_o,
  output logic      out_we_o,
  output logic      in_re_o,
  output logic      wgt_re_o,
  output logic      out_re_o,
  input  axi_data_t in_rdata_i,
  input  axi_data_t wgt_rdata_i,
  input  axi_data_t out_rdata_i,
  // Register file
  output logic      ctrl_we_o,
  output logic      scale_we_o,
  output logic      offs_we_o,
  input  axi_data_t status_i
);

  slave_state_t state_q, state_d;
  logic aw_hs, ar_hs, w_hs, r_hs;
  axi_addr_t addr_q;
  axi_id_t id_q;
  axi_len_t len_q;
  axi_len_t beat_q;
  axi_data_t stat_q;
  logic [7:0] region;
  logic last_beat;

  assign s_awready_o = (state_q == IDLE);
  assign s_arready_o = (state_q == IDLE) && !s_awvalid_i;
  assign s_wready_o = (state_q == W_CH);
  assign s_bvalid_o = (state_q == B_CH);
  assign s_rvalid_o = (state_q == R_DATA);

  assign aw_hs = s_awvalid_i && s_awready_o;
  assign ar_hs = s_arvalid_i && s_arready_o;
  assign w_hs = s_wvalid_i && s_wready_o;
  assign r_hs = s_rvalid_o && s_rready_i;

  assign last_beat = (beat_q == len_q);
  assign s_rlast_o = s_rvalid_o && last_beat;
  assign s_bid_o = id_q;
  assign s_rid_o = id_q;
  assign s_bresp_o = RESP_OKAY;
  assign s_rresp_o = RESP_OKAY;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (aw_hs) begin
          state_d = W_CH;
        end else if (ar_hs) begin
          state_d = R_ADDR;
        end
      end
      W_CH: if (w_hs && s_wlast_i) state_d = B_CH;
      B_CH: if (s_bready_i) state_d = IDLE;
      R_ADDR: state_d = R_DATA;
      R_DATA: if (r_hs) state_d = last_beat ? IDLE : R_ADDR;
      default: state_d = IDLE;
    endcase
  end

  // Burst attributes are sampled once per address handshake
  always_ff @(posedge clk) begin
    if (aw_hs) begin
      addr_q <= s_awaddr_i;
      id_q <= s_awid_i;
      len_q <= s_awlen_i;
    end else if (ar_hs) begin
      addr_q <= s_araddr_i;
      id_q <= s_arid_i;
      len_q <= s_arlen_i;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      beat_q <= '0;
    end else if (aw_hs || ar_hs) begin
      beat_q <= '0;
    end else if (w_hs || r_hs) begin
      beat_q <= beat_q + 8'd1;
    end
  end

  // Word index is the start index plus the beat count
  assign bus_addr_o = addr_q[7:2] + beat_q[BUF_AW-1:0];
  assign bus_wdata_o = s_wdata_i;
  assign region = addr_q[31:24];

  assign in_we_o = w_hs && (region == REG_IN);
  assign out_we_o = w_hs && (region == REG_OUT);
  assign wgt_we_o = w_hs && (region == REG_WGT);
  assign ctrl_we_o = w_hs && (region == REG_CTRL);
  assign scale_we_o = w_hs && (region == REG_SCALE);
  assign offs_we_o = w_hs && (region == REG_OFFS);

  assign in_re_o = (state_q == R_ADDR) && (region == REG_IN);
  assign out_re_o = (state_q == R_ADDR) && (region == REG_OUT);
  assign wgt_re_o = (state_q == R_ADDR) && (region == REG_WGT);

  // Status is sampled alongside the buffer read so it holds under back-pressure
  always_ff @(posedge clk) begin
    if (state_q == R_ADDR) begin
      stat_q <= status_i;
    end
  end

  always_comb begin
    case (region)
      REG_IN: s_rdata_o = in_rdata_i;
      REG_OUT: s_rdata_o = out_rdata_i;
      REG_WGT: s_rdata_o = wgt_rdata_i;
      REG_STAT: s_rdata_o = stat_q;
      default: s_rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/epu_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

module epu_buffer import epu_pkg::*; #(
  parameter int DEPTH_LOG2 = BUF_AW
) (
  input  logic                  clk,
  // Port a
  input  logic [DEPTH_LOG2-1:0] a_addr_i,
  input  logic                  a_we_i,
  input  axi_data_t             a_wdata_i,
  input  logic                  a_re_i,
  output axi_data_t             a_rdata_o,
  // Port b
  input  logic [DEPTH_LOG2-1:0] b_addr_i,
  input  logic                  b_we_i,
  input  axi_data_t             b_wdata_i,
  input  logic                  b_re_i,
  output axi_data_t             b_rdata_o
);

  axi_data_t mem [2**DEPTH_LOG2];

  // Port b wins when both ports write the same word
  always_ff @(posedge clk) begin
    if (a_we_i) begin
      mem[a_addr_i] <= a_wdata_i;
    end
    if (b_we_i) begin
      mem[b_addr_i] <= b_wdata_i;
    end
    // Read data holds until the next read enable
    if (a_re_i) begin
      a_rdata_o <= mem[a_addr_i];
    end
    if (b_re_i) begin
      b_rdata_o <= mem[b_addr_i];
    end
  end

endmodule

`default_nettype wire

/* rtl/epu_conv_engine.sv */
`timescale 1ns/10ps
`default_nettype none

module epu_conv_engine import epu_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      start_i,
  input  logic      mode_i,
  input  buf_addr_t count_i,
  input  elem_t     scale_i,
  input  elem_t     offset_i,
  // Input and weight read ports
  output buf_addr_t in_addr_o,
  output logic      in_re_o,
  input  axi_data_t in_rdata_i,
  output buf_addr_t wgt_addr_o,
  output logic      wgt_re_o,
  input  axi_data_t wgt_rdata_i,
  // Output write port
  output buf_addr_t out_addr_o,
  output logic      out_we_o,
  output axi_data_t out_wdata_o,
  output logic      done_o
);

  engine_state_t state_q;
  buf_addr_t rd_idx_q;
  buf_addr_t el_idx_q;
  logic valid_q;
  acc_t acc_q;
  elem_t in_el, wgt_el;
  acc_t prod, scaled;
  logic run;

  assign run = (state_q == E_RUN);

  // Read stage
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q <= E_IDLE;
      rd_idx_q <= '0;
    end else begin
      case (state_q)
        E_IDLE: begin
          rd_idx_q <= '0;
          if (start_i) state_q <= E_RUN;
        end
        E_RUN: begin
          if (rd_idx_q == count_i) begin
            state_q <= E_DRAIN;
          end else begin
            rd_idx_q <= rd_idx_q + 1'b1;
          end
        end
        // Last element is in the accumulate stage here
        E_DRAIN: state_q <= E_DONE;
        default: state_q <= E_IDLE;
      endcase
    end
  end

  assign in_addr_o = rd_idx_q;
  assign wgt_addr_o = rd_idx_q;
  assign in_re_o = run;
  assign wgt_re_o = run && !mode_i;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= run;
    end
  end

  always_ff @(posedge clk) begin
    el_idx_q <= rd_idx_q;
    if (start_i) begin
      acc_q <= '0;
    end else if (valid_q) begin
      acc_q <= acc_q + prod;
    end
  end

  // Accumulate/write stage
  assign in_el = in_rdata_i[15:0];
  assign wgt_el = wgt_rdata_i[15:0];
  assign prod = in_el * wgt_el;
  assign scaled = in_el * scale_i + offset_i;

  assign done_o = (state_q == E_DONE);
  assign out_we_o = (valid_q && mode_i) || (done_o && !mode_i);
  assign out_addr_o = mode_i ? el_idx_q : '0;
  assign out_wdata_o = mode_i ? scaled : acc_q;

endmodule

`default_nettype wire

/* rtl/epu_ctrl_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module epu_ctrl_regs import epu_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  axi_data_t wdata_i,
  input  logic      ctrl_we_i,
  input  logic      scale_we_i,
  input  logic      offs_we_i,
  input  logic      done_i,
  output logic      start_o,
  output logic      mode_o,
  output buf_addr_t count_o,
  output elem_t     scale_o,
  output elem_t     offset_o,
  output axi_data_t status_o
);

  logic busy_q;
  logic go;

  // Control writes while the engine runs are ignored
  assign go = ctrl_we_i && wdata_i[0] && !busy_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      start_o <= 1'b0;
      busy_q <= 1'b0;
      mode_o <= 1'b0;
      count_o <= '0;
      scale_o <= '0;
      offset_o <= '0;
    end else begin
      start_o <= go;
      if (go) begin
        busy_q <= 1'b1;
      end else if (done_i) begin
        busy_q <= 1'b0;
      end
      if (ctrl_we_i && !busy_q) begin
        mode_o <= wdata_i[1];
        count_o <= wdata_i[7:2];
      end
      if (scale_we_i) scale_o <= wdata_i[15:0];
      if (offs_we_i) offset_o <= wdata_i[15:0];
    end
  end

  assign status_o = {31'd0, busy_q};

endmodule

`default_nettype wire

/* rtl/epu_pkg.sv */
`default_nettype none

package epu_pkg;

  // Buffer address width for 64 words per buffer
  localparam int BUF_AW = 6;

  typedef logic [31:0] axi_addr_t;
  typedef logic [31:0] axi_data_t;
  typedef logic [3:0] axi_id_t;
  typedef logic [7:0] axi_len_t;
  typedef logic [1:0] axi_resp_t;
  typedef logic [BUF_AW-1:0] buf_addr_t;

  // Signed element in the low half of a word, and its 32-bit product
  typedef logic signed [15:0] elem_t;
  typedef logic signed [31:0] acc_t;

  localparam axi_resp_t RESP_OKAY = 2'd0;

  // Region codes compared against address bits 31:24
  localparam logic [7:0] REG_IN = 8'h50;
  localparam logic [7:0] REG_OUT = 8'h60;
  localparam logic [7:0] REG_WGT = 8'h70;
  localparam logic [7:0] REG_CTRL = 8'h80;
  localparam logic [7:0] REG_SCALE = 8'h81;
  localparam logic [7:0] REG_OFFS = 8'h82;
  localparam logic [7:0] REG_STAT = 8'h83;

  typedef enum logic [2:0] {
    IDLE,
    W_CH,
    B_CH,
    R_ADDR,
    R_DATA
  } slave_state_t;

  typedef enum logic [1:0] {
    E_IDLE,
    E_RUN,
    E_DRAIN,
    E_DONE
  } engine_state_t;

endpackage

`default_nettype wire

/* rtl/epu_top.sv */
`timescale 1ns/10ps
`default_nettype none

module epu_top import epu_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      s_awvalid_i,
  output logic      s_awready_o,
  input  axi_addr_t s_awaddr_i,
  input  axi_id_t   s_awid_i,
  input  axi_len_t  s_awlen_i,
  input  logic      s_wvalid_i,
  output logic      s_wready_o,
  input  axi_data_t s_wdata_i,
  input  logic      s_wlast_i,
  output logic      s_bvalid_o,
  input  logic      s_bready_i,
  output axi_id_t   s_bid_o,
  output axi_resp_t s_bresp_o,
  input  logic      s_arvalid_i,
  output logic      s_arready_o,
  input  axi_addr_t s_araddr_i,
  input  axi_id_t   s_arid_i,
  input  axi_len_t  s_arlen_i,
  output logic      s_rvalid_o,
  input  logic      s_rready_i,
  output axi_data_t s_rdata_o,
  output axi_id_t   s_rid_o,
  output axi_resp_t s_rresp_o,
  output logic      s_rlast_o,
  output logic      epuint_o
);

  // Slave side of the buffers
  buf_addr_t bus_addr;
  axi_data_t bus_wdata;
  logic in_we, wgt_we, out_we;
  logic in_re, wgt_re, out_re;
  axi_data_t in_rdata, wgt_rdata, out_rdata;

  // Register file and engine control
  logic ctrl_we, scale_we, offs_we;
  axi_data_t status;
  logic start, mode, done;
  buf_addr_t count;
  elem_t scale, offset;

  // Engine side of the buffers
  buf_addr_t eng_in_addr, eng_wgt_addr, eng_out_addr;
  logic eng_in_re, eng_wgt_re, eng_out_we;
  axi_data_t eng_in_rdata, eng_wgt_rdata, eng_out_wdata;

  assign epuint_o = done;

  epu_axi_slave u_slave (
    .clk(clk), .rst(rst),
    .s_awvalid_i(s_awvalid_i), .s_awready_o(s_awready_o), .s_awaddr_i(s_awaddr_i),
    .s_awid_i(s_awid_i), .s_awlen_i(s_awlen_i),
    .s_wvalid_i(s_wvalid_i), .s_wready_o(s_wready_o), .s_wdata_i(s_wdata_i),
    .s_wlast_i(s_wlast_i),
    .s_bvalid_o(s_bvalid_o), .s_bready_i(s_bready_i), .s_bid_o(s_bid_o),
    .s_bresp_o(s_bresp_o),
    .s_arvalid_i(s_arvalid_i), .s_arready_o(s_arready_o), .s_araddr_i(s_araddr_i),
    .s_arid_i(s_arid_i), .s_arlen_i(s_arlen_i),
    .s_rvalid_o(s_rvalid_o), .s_rready_i(s_rready_i), .s_rdata_o(s_rdata_o),
    .s_rid_o(s_rid_o), .s_rresp_o(s_rresp_o), .s_rlast_o(s_rlast_o),
    .bus_addr_o(bus_addr), .bus_wdata_o(bus_wdata),
    .in_we_o(in_we), .wgt_we_o(wgt_we), .out_we_o(out_we),
    .in_re_o(in_re), .wgt_re_o(wgt_re), .out_re_o(out_re),
    .in_rdata_i(in_rdata), .wgt_rdata_i(wgt_rdata), .out_rdata_i(out_rdata),
    .ctrl_we_o(ctrl_we), .scale_we_o(scale_we), .offs_we_o(offs_we),
    .status_i(status)
  );

  // Port b of the input and weight buffers is read only
  epu_buffer u_in_buf (
    .clk(clk),
    .a_addr_i(bus_addr), .a_we_i(in_we), .a_wdata_i(bus_wdata),
    .a_re_i(in_re), .a_rdata_o(in_rdata),
    .b_addr_i(eng_in_addr), .b_we_i(1'b0), .b_wdata_i('0),
    .b_re_i(eng_in_re), .b_rdata_o(eng_in_rdata)
  );

  epu_buffer u_wgt_buf (
    .clk(clk),
    .a_addr_i(bus_addr), .a_we_i(wgt_we), .a_wdata_i(bus_wdata),
    .a_re_i(wgt_re), .a_rdata_o(wgt_rdata),
    .b_addr_i(eng_wgt_addr), .b_we_i(1'b0), .b_wdata_i('0),
    .b_re_i(eng_wgt_re), .b_rdata_o(eng_wgt_rdata)
  );

  // Engine only writes the output buffer
  epu_buffer u_out_buf (
    .clk(clk),
    .a_addr_i(bus_addr), .a_we_i(out_we), .a_wdata_i(bus_wdata),
    .a_re_i(out_re), .a_rdata_o(out_rdata),
    .b_addr_i(eng_out_addr), .b_we_i(eng_out_we), .b_wdata_i(eng_out_wdata),
    .b_re_i(1'b0), .b_rdata_o()
  );

  epu_ctrl_regs u_regs (
    .clk(clk), .rst(rst),
    .wdata_i(bus_wdata), .ctrl_we_i(ctrl_we), .scale_we_i(scale_we),
    .offs_we_i(offs_we), .done_i(done),
    .start_o(start), .mode_o(mode), .count_o(count),
    .scale_o(scale), .offset_o(offset), .status_o(status)
  );

  epu_conv_engine u_engine (
    .clk(clk), .rst(rst),
    .start_i(start), .mode_i(mode), .count_i(count),
    .scale_i(scale), .offset_i(offset),
    .in_addr_o(eng_in_addr), .in_re_o(eng_in_re), .in_rdata_i(eng_in_rdata),
    .wgt_addr_o(eng_wgt_addr), .wgt_re_o(eng_wgt_re), .wgt_rdata_i(eng_wgt_rdata),
    .out_addr_o(eng_out_addr), .out_we_o(eng_out_we), .out_wdata_o(eng_out_wdata),
    .done_o(done)
  );

endmodule

`default_nettype wire

/* test/epu_chk.sv */
`timescale 1ns/10ps
`default_nettype none

module epu_axi_chk import epu_pkg::*; (
  input logic      clk,
  input logic      rst,
  input logic      awready_i,
  input logic      wready_i,
  input logic      bvalid_i,
  input logic      bready_i,
  input axi_id_t   bid_i,
  input logic      rvalid_i,
  input logic      rready_i,
  input axi_data_t rdata_i,
  input axi_id_t   rid_i,
  input logic      rlast_i
);

  int fail_count = 0;

  // Write response waits for bready with a stable ID
  assert property (@(posedge clk) disable iff (rst)
    bvalid_i && !bready_i |=> bvalid_i && $stable(bid_i))
    else begin
      fail_count++;
      $error("bvalid dropped or bid changed before the handshake");
    end

  assert property (@(posedge clk) disable iff (rst)
    rvalid_i && !rready_i |=>
      rvalid_i && $stable(rdata_i) && $stable(rid_i) && $stable(rlast_i))
    else begin
      fail_count++;
      $error("rvalid dropped or read beat changed before the handshake");
    end

  assert property (@(posedge clk) disable iff (rst) !(awready_i && wready_i))
    else begin
      fail_count++;
      $error("awready and wready high together");
    end

  assert property (@(posedge clk) disable iff (rst) rlast_i |-> rvalid_i)
    else begin
      fail_count++;
      $error("rlast high without rvalid");
    end

endmodule

bind epu_axi_slave epu_axi_chk u_chk (
  .clk(clk), .rst(rst),
  .awready_i(s_awready_o), .wready_i(s_wready_o),
  .bvalid_i(s_bvalid_o), .bready_i(s_bready_i), .bid_i(s_bid_o),
  .rvalid_i(s_rvalid_o), .rready_i(s_rready_i), .rdata_i(s_rdata_o),
  .rid_i(s_rid_o), .rlast_i(s_rlast_o)
);

`default_nettype wire

/* test/epu_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module epu_tb import epu_pkg::*; ();

  logic      clk;
  logic      rst;
  logic      s_awvalid_i;
  logic      s_awready_o;
  axi_addr_t s_awaddr_i;
  axi_id_t   s_awid_i;
  axi_len_t  s_awlen_i;
  logic      s_wvalid_i;
  logic      s_wready_o;
  axi_data_t s_wdata_i;
  logic      s_wlast_i;
  logic      s_bvalid_o;
  logic      s_bready_i;
  axi_id_t   s_bid_o;
  axi_resp_t s_bresp_o;
  logic      s_arvalid_i;
  logic      s_arready_o;
  axi_addr_t s_araddr_i;
  axi_id_t   s_arid_i;
  axi_len_t  s_arlen_i;
  logic      s_rvalid_o;
  logic      s_rready_i;
  axi_data_t s_rdata_o;
  axi_id_t   s_rid_o;
  axi_resp_t s_rresp_o;
  logic      s_rlast_o;
  logic      epuint_o;

  typedef enum int {F_AWREADY, F_WREADY, F_BVALID, F_ARREADY, F_RVALID, F_IRQ} flag_t;

  integer seed;
  int check_errors;
  int timeouts;
  axi_data_t wr_buf [64];
  axi_data_t rd_buf [64];
  axi_data_t in_ref [8];
  axi_data_t wgt_ref [8];
  axi_data_t out_ref [8];

  epu_top uut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check_val(input string name, input axi_data_t got, input axi_data_t exp);
    assert (got === exp) else begin
      $display("Fail at %0d ns: %s = %h, expected %h", $time, name, got, exp);
      check_errors++;
    end
  endtask

  function automatic logic flag_value(input flag_t sel);
    case (sel)
      F_AWREADY: return s_awready_o;
      F_WREADY: return s_wready_o;
      F_BVALID: return s_bvalid_o;
      F_ARREADY: return s_arready_o;
      F_RVALID: return s_rvalid_o;
      default: return epuint_o;
    endcase
  endfunction

  // Polls in the middle of the low clock phase, where outputs are settled
  task automatic wait_high(input flag_t sel, input string what, output bit ok);
    int n;
    ok = 1'b0;
    n = 0;
    #1;
    while (!flag_value(sel)) begin
      n++;
      if (n > 200) begin
        $display("Timeout at %0d ns: %s never went high", $time, what);
        timeouts++;
        return;
      end
      @(negedge clk);
      #1;
    end
    ok = 1'b1;
  endtask

  task automatic axi_write_burst(input axi_addr_t addr, input axi_id_t id, input int n,
                                 input int bdelay);
    bit ok;
    @(negedge clk);
    s_awvalid_i = 1'b1;
    s_awaddr_i = addr;
    s_awid_i = id;
    s_awlen_i = axi_len_t'(n - 1);
    wait_high(F_AWREADY, "s_awready_o", ok);
    @(negedge clk);
    s_awvalid_i = 1'b0;
    for (int b = 0; b < n && ok; b++) begin
      s_wvalid_i = 1'b1;
      s_wdata_i = wr_buf[b];
      s_wlast_i = (b == n - 1);
      wait_high(F_WREADY, "s_wready_o", ok);
      @(negedge clk);
    end
    s_wvalid_i = 1'b0;
    s_wlast_i = 1'b0;
    s_bready_i = (bdelay == 0);
    if (ok) wait_high(F_BVALID, "s_bvalid_o", ok);
    if (ok) begin
      check_val("s_bid_o", s_bid_o, id);
      check_val("s_bresp_o", s_bresp_o, RESP_OKAY);
      if (bdelay > 0) begin
        repeat (bdelay) @(negedge clk);
        s_bready_i = 1'b1;
        #1;
        check_val("s_bvalid_o", s_bvalid_o, 1);
      end
      @(negedge clk);
    end
    s_bready_i = 1'b0;
  endtask

  task automatic axi_read_burst(input axi_addr_t addr, input axi_id_t id, input int n,
                                input bit stall);
    bit ok;
    axi_data_t first;
    @(negedge clk);
    s_arvalid_i = 1'b1;
    s_araddr_i = addr;
    s_arid_i = id;
    s_arlen_i = axi_len_t'(n - 1);
    wait_high(F_ARREADY, "s_arready_o", ok);
    @(negedge clk);
    s_arvalid_i = 1'b0;
    s_rready_i = !stall;
    for (int b = 0; b < n && ok; b++) begin
      wait_high(F_RVALID, "s_rvalid_o", ok);
      if (ok) begin
        first = s_rdata_o;
        if (stall) begin
          // rready stays low for one to four cycles
          repeat (1 + ($random(seed) & 3)) @(negedge clk);
          s_rready_i = 1'b1;
          #1;
          check_val("s_rvalid_o", s_rvalid_o, 1);
          check_val("s_rdata_o", s_rdata_o, first);
        end
        rd_buf[b] = s_rdata_o;
        check_val("s_rid_o", s_rid_o, id);
        check_val("s_rresp_o", s_rresp_o, RESP_OKAY);
        check_val("s_rlast_o", s_rlast_o, b == n - 1);
        @(negedge clk);
        s_rready_i = !stall;
      end
    end
    s_rready_i = 1'b0;
  endtask

  task automatic wait_irq();
    bit ok;
    wait_high(F_IRQ, "epuint_o", ok);
    if (ok) begin
      @(negedge clk);
      #1;
      assert (!epuint_o) else begin
        $display("Interrupt stayed high for more than one cycle at %0d ns", $time);
        check_errors++;
      end
    end
  endtask

  task automatic fill_random(input int n);
    for (int i = 0; i < n; i++) wr_buf[i] = $random(seed);
  endtask

  task automatic compare_read(input axi_data_t exp [8], input int n);
    for (int i = 0; i < n; i++) check_val($sformatf("s_rdata_o[%0d]", i), rd_buf[i], exp[i]);
  endtask

  task automatic test_reset();
    #1;
    check_val("s_bvalid_o", s_bvalid_o, 0);
    check_val("s_rvalid_o", s_rvalid_o, 0);
    check_val("s_wready_o", s_wready_o, 0);
    check_val("epuint_o", epuint_o, 0);
    check_val("s_awready_o", s_awready_o, 1);
    check_val("s_arready_o", s_arready_o, 1);
    axi_read_burst(32'h8300_0000, 4'd1, 1, 1'b0);
    check_val("status", rd_buf[0], 0);
  endtask

  task automatic test_buffers();
    fill_random(8);
    for (int i = 0; i < 8; i++) in_ref[i] = wr_buf[i];
    axi_write_burst(32'h5000_0000, 4'd3, 8, 0);
    fill_random(8);
    for (int i = 0; i < 8; i++) wgt_ref[i] = wr_buf[i];
    axi_write_burst(32'h7000_0000, 4'd4, 8, 0);
    axi_read_burst(32'h5000_0000, 4'd5, 8, 1'b0);
    compare_read(in_ref, 8);
    axi_read_burst(32'h7000_0000, 4'd6, 8, 1'b0);
    compare_read(wgt_ref, 8);
  endtask

  task automatic test_backpressure();
    axi_data_t out_exp [8];
    axi_read_burst(32'h5000_0000, 4'd9, 8, 1'b1);
    compare_read(in_ref, 8);
    fill_random(4);
    for (int i = 0; i < 8; i++) out_exp[i] = wr_buf[i];
    axi_write_burst(32'h6000_0000, 4'd10, 4, 3);
    axi_read_burst(32'h6000_0000, 4'd11, 4, 1'b0);
    compare_read(out_exp, 4);
  endtask

  // Dot product over eight elements with a 32-bit wrapping sum
  task automatic test_dot();
    int sum;
    elem_t a;
    elem_t w;
    sum = 0;
    for (int i = 0; i < 8; i++) begin
      a = in_ref[i][15:0];
      w = wgt_ref[i][15:0];
      sum = sum + int'(a) * int'(w);
    end
    wr_buf[0] = {24'd0, 6'd7, 1'b0, 1'b1};
    axi_write_burst(32'h8000_0000, 4'd7, 1, 0);
    wait_irq();
    axi_read_burst(32'h8300_0000, 4'd8, 1, 1'b0);
    check_val("status", rd_buf[0], 0);
    axi_read_burst(32'h6000_0000, 4'd2, 1, 1'b0);
    check_val("output[0]", rd_buf[0], sum);
  endtask

  task automatic test_scale();
    elem_t scale;
    elem_t offs;
    elem_t a;
    scale = -16'sd3;
    offs = 16'h8005;
    for (int i = 0; i < 8; i++) begin
      a = in_ref[i][15:0];
      out_ref[i] = int'(a) * int'(scale) + int'(offs);
    end
    // Upper halves are ignored by the registers
    wr_buf[0] = {16'habcd, scale};
    axi_write_burst(32'h8100_0000, 4'd1, 1, 0);
    wr_buf[0] = {16'h1234, offs};
    axi_write_burst(32'h8200_0000, 4'd2, 1, 0);
    wr_buf[0] = {24'd0, 6'd7, 1'b1, 1'b1};
    axi_write_burst(32'h8000_0000, 4'd3, 1, 0);
    wait_irq();
    axi_read_burst(32'h6000_0000, 4'd4, 8, 1'b0);
    compare_read(out_ref, 8);
  endtask

  task automatic test_unmapped();
    axi_data_t zeros [8];
    for (int i = 0; i < 8; i++) zeros[i] = '0;
    axi_read_burst(32'h9000_0000, 4'd12, 4, 1'b0);
    compare_read(zeros, 4);
    fill_random(4);
    axi_write_burst(32'h9000_0000, 4'd13, 4, 0);
    axi_read_burst(32'h5000_0000, 4'd14, 8, 1'b0);
    compare_read(in_ref, 8);
    axi_read_burst(32'h7000_0000, 4'd15, 8, 1'b0);
    compare_read(wgt_ref, 8);
    axi_read_burst(32'h6000_0000, 4'd0, 8, 1'b0);
    compare_read(out_ref, 8);
  endtask

  initial begin
    seed = 32'he5e2;
    check_errors = 0;
    timeouts = 0;
    rst = 1'b1;
    s_awvalid_i = 1'b0;
    s_awaddr_i = '0;
    s_awid_i = '0;
    s_awlen_i = '0;
    s_wvalid_i = 1'b0;
    s_wdata_i = '0;
    s_wlast_i = 1'b0;
    s_bready_i = 1'b0;
    s_arvalid_i = 1'b0;
    s_araddr_i = '0;
    s_arid_i = '0;
    s_arlen_i = '0;
    s_rready_i = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_reset();
    test_buffers();
    test_backpressure();
    test_dot();
    test_scale();
    test_unmapped();
    $display("Errors: %0d check failures, %0d timeouts, %0d protocol assertion failures",
             check_errors, timeouts, uut.u_slave.u_chk.fail_count);
    if (check_errors == 0 && timeouts == 0 && uut.u_slave.u_chk.fail_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire
